//--- cu_bundles.f
verilog/cu_bundles_pkg.sv
verilog/response_router.sv
verilog/bundle_engine.sv
verilog/request_arbiter.sv
verilog/result_collector.sv
verilog/cu_bundles.sv
verification/cu_bundles_tb.sv

//--- Makefile
# Verilator build and run of the cu_bundles testbench
TOP = cu_bundles_tb

all: run

run:
	verilator --binary --timing --assert -f cu_bundles.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f cu_bundles.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

//--- verification/cu_bundles_tb.sv
// ----------------------------------------
// Testbench for the compute-unit cluster
// Stimulus table, memory responder model,
// request scoreboard and row reporting
// ----------------------------------------
`timescale 1ns/10ps

module cu_bundles_tb import cu_bundles_pkg::*; ();

    // One stimulus row with its expected total
    typedef struct packed {
        logic [addr_width-1:0]   base_addr;
        logic [length_width-1:0] length;
        logic [7:0]              max_delay;
        bundle_sum_t             expected_sum;
    } table_row_t;

    localparam int num_rows     = 6;
    localparam int max_words    = num_bundles * 256;
    localparam int done_timeout = 20000;
    localparam int idle_cycles  = 20;

    // ----------------------------------------
    // DUT signals
    // ----------------------------------------
    logic               ap_clk = 1'b0;
    logic               areset;
    kernel_descriptor_t descriptor_in;
    memory_packet_t     response_memory_in;
    memory_packet_t     request_memory_out;
    bundle_sum_t        result_sum;
    logic               done_out;

    // Responder and scoreboard state
    table_row_t              stim_table [num_rows];
    integer                  seed = 32'h73ae9bd9;
    memory_packet_t          pending [$];
    bit                      seen [max_words];
    logic [addr_width-1:0]   cur_base;
    logic [length_width-1:0] cur_length;
    int                      cur_delay;
    int                      delay_left;
    int                      cycle;
    int                      req_count;
    int                      first_req_cycle;
    int                      last_req_cycle;
    int                      row_errors;
    int                      pass_count;
    int                      fail_count;
    bit                      timed_out;

    always #5 ap_clk = ~ap_clk;

    cu_bundles u_cu_bundles (
        .ap_clk             (ap_clk),
        .areset             (areset),
        .descriptor_in      (descriptor_in),
        .response_memory_in (response_memory_in),
        .request_memory_out (request_memory_out),
        .result_sum         (result_sum),
        .done_out           (done_out)
    );

    // ----------------------------------------
    // Memory rule and expected values
    // ----------------------------------------
    // Word at an address is address * 3 + 1 modulo 2**32
    function automatic logic [data_width-1:0] memory_data(logic [addr_width-1:0] addr);
        return addr * 32'd3 + 32'd1;
    endfunction

    // Total over every slice of a row
    function automatic bundle_sum_t expected_total(logic [addr_width-1:0] base,
                                                   logic [length_width-1:0] length);
        bundle_sum_t total;
        int          words;
        total = '0;
        words = num_bundles * int'(length);
        for (int i = 0; i < words; i++) begin
            total = total + memory_data(base + addr_width'(i));
        end
        return total;
    endfunction

    function automatic void set_row(int r, logic [addr_width-1:0] base,
                                    logic [length_width-1:0] length, logic [7:0] max_delay);
        stim_table[r].base_addr    = base;
        stim_table[r].length       = length;
        stim_table[r].max_delay    = max_delay;
        stim_table[r].expected_sum = expected_total(base, length);
    endfunction

    // ----------------------------------------
    // Request scoreboard
    // ----------------------------------------
    // Offset from the row base picks the slot and the owning bundle
    task automatic check_request(memory_packet_t req);
        logic [addr_width-1:0] offset;
        int                    total;
        offset = req.word.addr - cur_base;
        total  = num_bundles * int'(cur_length);
        if (req_count == 0) begin
            first_req_cycle = cycle;
        end
        last_req_cycle = cycle;
        req_count++;
        assert (offset < addr_width'(total)) else begin
            $display("unexpected request at %0t for address %h", $time, req.word.addr);
            row_errors++;
        end
        if (offset < addr_width'(total)) begin
            assert (!seen[int'(offset)]) else begin
                $display("address %h requested twice at %0t", req.word.addr, $time);
                row_errors++;
            end
            assert (req.id == bundle_id_t'(offset / addr_width'(cur_length))) else begin
                $display("mismatch at %0t: request_memory_out.id expected %0d actual %0d",
                         $time, offset / addr_width'(cur_length), req.id);
                row_errors++;
            end
            seen[int'(offset)] = 1'b1;
        end
    endtask

    // ----------------------------------------
    // Memory responder stepped once per cycle
    // ----------------------------------------
    // Queued requests answered out of order after a random gap
    task automatic step_cycle();
        int unsigned    pick;
        memory_packet_t req;
        @(negedge ap_clk);
        cycle++;
        if (request_memory_out.valid) begin
            check_request(request_memory_out);
            pending.push_back(request_memory_out);
        end
        response_memory_in = '0;
        if (pending.size() > 0) begin
            if (delay_left > 0) begin
                delay_left--;
            end else begin
                pick = $unsigned($random(seed)) % pending.size();
                req  = pending[pick];
                pending.delete(pick);
                // Echoed id and the data view of the word
                response_memory_in.valid     = 1'b1;
                response_memory_in.id        = req.id;
                response_memory_in.word.data = memory_data(req.word.addr);
                delay_left = int'($unsigned($random(seed)) % (cur_delay + 1));
            end
        end
    endtask

    // ----------------------------------------
    // Test steps
    // ----------------------------------------
    // Quiet outputs before any descriptor
    task automatic check_idle();
        row_errors = 0;
        for (int i = 0; i < idle_cycles; i++) begin
            step_cycle();
            assert (!request_memory_out.valid) else begin
                $display("mismatch at %0t: request_memory_out.valid expected 0 actual %b",
                         $time, request_memory_out.valid);
                row_errors++;
            end
            assert (!done_out) else begin
                $display("mismatch at %0t: done_out expected 0 actual %b", $time, done_out);
                row_errors++;
            end
            assert (result_sum == '0) else begin
                $display("mismatch at %0t: result_sum expected %h actual %h",
                         $time, bundle_sum_t'(0), result_sum);
                row_errors++;
            end
        end
        $display("idle after reset: %s, %0d errors", (row_errors == 0) ? "pass" : "fail",
                 row_errors);
        if (row_errors == 0) begin
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    task automatic run_row(int r);
        table_row_t row;
        int         waited;
        int         total;
        row        = stim_table[r];
        cur_base   = row.base_addr;
        cur_length = row.length;
        cur_delay  = int'(row.max_delay);
        total      = num_bundles * int'(row.length);
        row_errors = 0;
        req_count  = 0;
        delay_left = 0;
        foreach (seen[i]) begin
            seen[i] = 1'b0;
        end
        // One-cycle descriptor strobe
        descriptor_in.valid     = 1'b1;
        descriptor_in.base_addr = row.base_addr;
        descriptor_in.length    = row.length;
        step_cycle();
        descriptor_in.valid = 1'b0;
        // Old done_out is gone two cycles after the strobe
        step_cycle();
        waited = 0;
        while (!done_out && waited < done_timeout) begin
            step_cycle();
            waited++;
        end
        if (!done_out) begin
            $display("row %0d: done_out never arrived within %0d cycles", r, done_timeout);
            timed_out = 1'b1;
            fail_count++;
        end else begin
            assert (result_sum == row.expected_sum) else begin
                $display("mismatch at %0t: result_sum expected %h actual %h",
                         $time, row.expected_sum, result_sum);
                row_errors++;
            end
            assert (req_count == total) else begin
                $display("row %0d: %0d requests seen where %0d were due", r, req_count, total);
                row_errors++;
            end
            assert (pending.size() == 0) else begin
                $display("row %0d: done_out rose with responses still owed", r);
                row_errors++;
            end
            // With zero delay the arbiter streams one request per cycle
            if (row.max_delay == 8'd0 && total > 0) begin
                assert (last_req_cycle - first_req_cycle + 1 == total) else begin
                    $display("row %0d: request strobes were not back to back", r);
                    row_errors++;
                end
            end
            $display("row %0d base %h length %0d delay %0d: %s, %0d errors", r,
                     row.base_addr, row.length, row.max_delay,
                     (row_errors == 0) ? "pass" : "fail", row_errors);
            if (row_errors == 0) begin
                pass_count++;
            end else begin
                fail_count++;
            end
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        areset             = 1'b1;
        descriptor_in      = '0;
        response_memory_in = '0;
        cur_base           = '0;
        cur_length         = '0;
        cur_delay          = 0;
        cycle              = 0;
        pass_count         = 0;
        fail_count         = 0;
        timed_out          = 1'b0;
        // No delay, random, zero length, long delay with wrap, random, single word
        set_row(0, 32'h0000_1000, 8'd8, 8'd0);
        set_row(1, 32'h0000_2000, 8'd16, 8'd4);
        set_row(2, 32'h0000_3000, 8'd0, 8'd3);
        set_row(3, 32'hffff_fff0, 8'd6, 8'd25);
        set_row(4, 32'h1234_5678, 8'd40, 8'd2);
        set_row(5, 32'h8000_0001, 8'd1, 8'd0);
        for (int i = 0; i < 10; i++) begin
            @(negedge ap_clk);
        end
        areset = 1'b0;
        check_idle();
        for (int r = 0; r < num_rows && !timed_out; r++) begin
            run_row(r);
        end
        $display("summary: %0d rows pass, %0d rows fail", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : cu_bundles_tb

//--- verilog/cu_bundles.sv
// ----------------------------------------
// Compute-unit cluster top level
// Reset and descriptor registers, router,
// bundle engines, arbiter and collector
// ----------------------------------------
`timescale 1ns/10ps

module cu_bundles import cu_bundles_pkg::*; (
    input  logic               ap_clk,
    input  logic               areset,
    input  kernel_descriptor_t descriptor_in,
    input  memory_packet_t     response_memory_in,
    output memory_packet_t     request_memory_out,
    output bundle_sum_t        result_sum,
    output logic               done_out
);

    // ----------------------------------------
    // Wires and registers
    // ----------------------------------------
    logic               areset_cu_bundles;
    kernel_descriptor_t descriptor_reg;

    // Per-bundle response and request packets
    memory_packet_t bundle_response [num_bundles];
    memory_packet_t bundle_request  [num_bundles];

    // Arbiter grants, one bit per bundle
    logic [num_bundles-1:0] bundle_grant;

    // Engine results toward the collector
    logic [num_bundles-1:0] bundle_done;
    bundle_sum_t            bundle_sum [num_bundles];

    // ----------------------------------------
    // Reset register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        areset_cu_bundles <= areset;
    end

    // ----------------------------------------
    // Descriptor register
    // ----------------------------------------
    // Descriptor held one cycle before the engines
    always_ff @(posedge ap_clk) begin
        descriptor_reg.base_addr <= descriptor_in.base_addr;
        descriptor_reg.length    <= descriptor_in.length;
        if (areset_cu_bundles) begin
            descriptor_reg.valid <= 1'b0;
        end else begin
            descriptor_reg.valid <= descriptor_in.valid;
        end
    end

    // ----------------------------------------
    // Response routing
    // ----------------------------------------
    response_router u_response_router (
        .ap_clk            (ap_clk),
        .areset_cu_bundles (areset_cu_bundles),
        .response_in       (response_memory_in),
        .response_out      (bundle_response)
    );

    // ----------------------------------------
    // Bundle engines
    // ----------------------------------------
    // Every bundle gets the same descriptor and picks its own slice
    for (genvar b = 0; b < num_bundles; b++) begin : gen_bundle
        bundle_engine #(
            .bundle_index (b)
        ) u_bundle_engine (
            .ap_clk            (ap_clk),
            .areset_cu_bundles (areset_cu_bundles),
            .descriptor        (descriptor_reg),
            .grant             (bundle_grant[b]),
            .response          (bundle_response[b]),
            .req_packet        (bundle_request[b]),
            .done              (bundle_done[b]),
            .sum               (bundle_sum[b])
        );
    end

    // ----------------------------------------
    // Request arbitration and result
    // ----------------------------------------
    request_arbiter u_request_arbiter (
        .ap_clk            (ap_clk),
        .areset_cu_bundles (areset_cu_bundles),
        .req_in            (bundle_request),
        .grant             (bundle_grant),
        .request_out       (request_memory_out)
    );

    result_collector u_result_collector (
        .ap_clk            (ap_clk),
        .areset_cu_bundles (areset_cu_bundles),
        .bundle_done       (bundle_done),
        .bundle_sum        (bundle_sum),
        .done_out          (done_out),
        .result_sum        (result_sum)
    );

endmodule : cu_bundles

//--- verilog/result_collector.sv
// ----------------------------------------
// Result collector, registered AND of the
// bundle done flags and total of sums
// ----------------------------------------
`timescale 1ns/10ps

module result_collector import cu_bundles_pkg::*; (
    input  logic                   ap_clk,
    input  logic                   areset_cu_bundles,
    input  logic [num_bundles-1:0] bundle_done,
    input  bundle_sum_t            bundle_sum [num_bundles],
    output logic                   done_out,
    output bundle_sum_t            result_sum
);

    // ----------------------------------------
    // Sum of bundle sums
    // ----------------------------------------
    // Wraps modulo 2**data_width like each bundle sum
    bundle_sum_t total_sum;

    always_comb begin
        total_sum = '0;
        for (int b = 0; b < num_bundles; b++) begin
            total_sum = total_sum + bundle_sum[b];
        end
    end

    // ----------------------------------------
    // Output registers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_bundles) begin
            done_out   <= 1'b0;
            result_sum <= '0;
        end else begin
            // Done only once every bundle is done
            done_out   <= &bundle_done;
            result_sum <= total_sum;
        end
    end

endmodule : result_collector

//--- verilog/request_arbiter.sv
// ----------------------------------------
// Round-robin request arbiter with a
// registered memory request output
// ----------------------------------------
`timescale 1ns/10ps

module request_arbiter import cu_bundles_pkg::*; (
    input  logic                   ap_clk,
    input  logic                   areset_cu_bundles,
    input  memory_packet_t         req_in [num_bundles],
    output logic [num_bundles-1:0] grant,
    output memory_packet_t         request_out
);

    // ----------------------------------------
    // Priority state
    // ----------------------------------------
    // Bundle granted last, search starts one past it
    bundle_id_t last_winner;
    bundle_id_t winner;
    logic       found;

    // ----------------------------------------
    // Winner search
    // ----------------------------------------
    always_comb begin
        int unsigned idx;
        winner = last_winner;
        found  = 1'b0;
        grant  = '0;
        // Walk the ring once, first pending bundle wins
        for (int k = 1; k <= num_bundles; k++) begin
            idx = (int'(last_winner) + k) % num_bundles;
            if (!found && req_in[idx].valid) begin
                found  = 1'b1;
                winner = bundle_id_t'(idx);
            end
        end
        if (found) begin
            grant[winner] = 1'b1;
        end
    end

    // ----------------------------------------
    // Output register and pointer update
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        request_out.id   <= req_in[winner].id;
        request_out.word <= req_in[winner].word;
        if (areset_cu_bundles) begin
            request_out.valid <= 1'b0;
            // Bundle 0 gets the first grant
            last_winner       <= bundle_id_t'(num_bundles - 1);
        end else begin
            request_out.valid <= found;
            if (found) begin
                last_winner <= winner;
            end
        end
    end

endmodule : request_arbiter

//--- verilog/bundle_engine.sv
// ----------------------------------------
// Bundle engine, read address generator
// for one slice plus response counter
// and data accumulator
// ----------------------------------------
`timescale 1ns/10ps

module bundle_engine import cu_bundles_pkg::*; #(
    parameter int bundle_index = 0
) (
    input  logic               ap_clk,
    input  logic               areset_cu_bundles,
    input  kernel_descriptor_t descriptor,
    input  logic               grant,
    input  memory_packet_t     response,
    output memory_packet_t     req_packet,
    output logic               done,
    output bundle_sum_t        sum
);

    // ----------------------------------------
    // Engine state
    // ----------------------------------------
    // Descriptor seen since reset
    logic                    started;
    // Words in this slice
    logic [length_width-1:0] length_reg;
    // Requests granted so far
    logic [length_width-1:0] issue_count;
    logic [length_width-1:0] issue_next;
    // Responses received so far
    logic [length_width-1:0] recv_count;
    // First address of this bundle's slice
    logic [addr_width-1:0]   slice_start;

    // ----------------------------------------
    // Slice start and next count
    // ----------------------------------------
    // base + index * length
    assign slice_start = descriptor.base_addr
                       + addr_width'(bundle_index) * addr_width'(descriptor.length);

    assign issue_next = issue_count + length_width'(1);

    // ----------------------------------------
    // Request generator
    // ----------------------------------------
    // Request held until granted, next address one cycle later
    always_ff @(posedge ap_clk) begin
        req_packet.id <= bundle_id_t'(bundle_index);
        if (areset_cu_bundles) begin
            req_packet.valid <= 1'b0;
            issue_count      <= '0;
            length_reg       <= '0;
            started          <= 1'b0;
        end else if (descriptor.valid) begin
            // New kernel, restart the slice
            req_packet.valid     <= (descriptor.length != '0);
            req_packet.word.addr <= slice_start;
            issue_count          <= '0;
            length_reg           <= descriptor.length;
            started              <= 1'b1;
        end else if (grant && req_packet.valid) begin
            // Granted, step to the next word
            req_packet.valid     <= (issue_next < length_reg);
            req_packet.word.addr <= req_packet.word.addr + addr_width'(1);
            issue_count          <= issue_next;
        end
    end

    // ----------------------------------------
    // Response accumulator
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_bundles) begin
            sum        <= '0;
            recv_count <= '0;
        end else if (descriptor.valid) begin
            sum        <= '0;
            recv_count <= '0;
        end else if (response.valid) begin
            // Data view of the returned word, wrapping add
            sum        <= sum + response.word.data;
            recv_count <= recv_count + length_width'(1);
        end
    end

    // ----------------------------------------
    // Done flag
    // ----------------------------------------
    // All responses back and no new kernel arriving
    assign done = started && (recv_count == length_reg) && !descriptor.valid;

endmodule : bundle_engine

//--- verilog/response_router.sv
// ----------------------------------------
// Response router, one memory response
// steered to its owning bundle by ID
// ----------------------------------------
`timescale 1ns/10ps

module response_router import cu_bundles_pkg::*; (
    input  logic           ap_clk,
    input  logic           areset_cu_bundles,
    input  memory_packet_t response_in,
    output memory_packet_t response_out [num_bundles]
);

    // ----------------------------------------
    // ID decode
    // ----------------------------------------
    // One-hot select of the owning bundle
    logic [num_bundles-1:0] route_sel;

    always_comb begin
        for (int b = 0; b < num_bundles; b++) begin
            route_sel[b] = response_in.valid && (response_in.id == bundle_id_t'(b));
        end
    end

    // ----------------------------------------
    // Registered fan-out
    // ----------------------------------------
    // Payload goes to every bundle
    // only the owner sees valid high
    always_ff @(posedge ap_clk) begin
        for (int b = 0; b < num_bundles; b++) begin
            response_out[b].id   <= response_in.id;
            response_out[b].word <= response_in.word;
            if (areset_cu_bundles) begin
                response_out[b].valid <= 1'b0;
            end else begin
                response_out[b].valid <= route_sel[b];
            end
        end
    end

endmodule : response_router

//--- verilog/cu_bundles_pkg.sv
// ----------------------------------------
// Cluster sizing localparams and the
// descriptor, memory word and packet types
// ----------------------------------------
package cu_bundles_pkg;

    // ----------------------------------------
    // Cluster sizing
    // ----------------------------------------
    // Bundles sharing the memory port
    localparam int num_bundles = 4;

    // Bundle ID bits, at least one
    localparam int bundle_id_width = (num_bundles > 1) ? $clog2(num_bundles) : 1;

    // Memory word sizing
    // Address and data widths are kept equal, one word holds either
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // Per-bundle word count
    localparam int length_width = 8;

    // ----------------------------------------
    // Shared types
    // ----------------------------------------
    // Owning bundle of a request or response
    typedef logic [bundle_id_width-1:0] bundle_id_t;

    // Kernel descriptor, valid is a one-cycle strobe
    typedef struct packed {
        logic                    valid;
        logic [addr_width-1:0]   base_addr;
        // Words per bundle
        logic [length_width-1:0] length;
    } kernel_descriptor_t;

    // One memory word, two readings
    // Requests carry an address, responses carry data
    typedef union packed {
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
    } memory_word_u;

    // Request or response on the memory port
    typedef struct packed {
        logic         valid;
        bundle_id_t   id;
        memory_word_u word;
    } memory_packet_t;

    // Accumulated sum, wraps modulo 2**data_width
    typedef logic [data_width-1:0] bundle_sum_t;

endpackage : cu_bundles_pkg
